//--- rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Width of the data path, the registers and the PC.
`define XLEN 32

// Number of architectural registers, x0 included.
`define REG_NUM 32

// Address of the first instruction fetched after reset.
`define RESET_PC 32'h8000_0000

`endif

//--- rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

    // Supported instructions. Everything else decodes to inst_illegal.
    typedef enum logic [4:0] {
        inst_illegal,
        inst_lui,
        inst_auipc,
        inst_jal,
        inst_jalr,
        inst_beq,
        inst_bne,
        inst_blt,
        inst_bge,
        inst_bltu,
        inst_bgeu,
        inst_addi,
        inst_sltiu,
        inst_xori,
        inst_andi,
        inst_slli,
        inst_srli,
        inst_srai,
        inst_add,
        inst_sub,
        inst_sll,
        inst_slt,
        inst_sltu,
        inst_xor,
        inst_or,
        inst_and,
        inst_ebreak
    } inst_num_e;

    typedef enum logic [2:0] {
        type_none,
        type_r,
        type_i,
        type_s,
        type_b,
        type_u,
        type_j
    } inst_type_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Stores and branches share this layout; only the immediate bits differ in meaning.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_b_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic [19:0] imm20; // Holds imm[20|10:1|11|19:12].
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } j_fmt_t;

    typedef union packed {
        logic [`XLEN-1:0] raw;
        r_fmt_t           r_fmt;
        i_fmt_t           i_fmt;
        s_b_fmt_t         s_b_fmt;
        u_fmt_t           u_fmt;
        j_fmt_t           j_fmt;
    } inst_word_u;

endpackage

//--- idu.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module idu (
    input  logic [`XLEN-1:0]   inst,
    output rv_pkg::inst_num_e  inst_num,
    output rv_pkg::inst_type_e inst_type,
    output logic [`XLEN-1:0]   imm,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic [4:0]         rd
);

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    rv_pkg::inst_word_u word;

    assign word.raw = inst;

    // Register fields sit at the same place in every format.
    assign rs1 = word.r_fmt.rs1;
    assign rs2 = word.r_fmt.rs2;
    assign rd  = word.r_fmt.rd;

    always_comb begin
        inst_num  = rv_pkg::inst_illegal;
        inst_type = rv_pkg::type_none;
        case (word.r_fmt.opcode)
            OP_LUI: begin
                inst_num  = rv_pkg::inst_lui;
                inst_type = rv_pkg::type_u;
            end
            OP_AUIPC: begin
                inst_num  = rv_pkg::inst_auipc;
                inst_type = rv_pkg::type_u;
            end
            OP_JAL: begin
                inst_num  = rv_pkg::inst_jal;
                inst_type = rv_pkg::type_j;
            end
            OP_JALR: begin
                inst_type = rv_pkg::type_i;
                if (word.i_fmt.funct3 == 3'b000) inst_num = rv_pkg::inst_jalr;
            end
            OP_BRANCH: begin
                inst_type = rv_pkg::type_b;
                case (word.s_b_fmt.funct3)
                    3'b000:  inst_num = rv_pkg::inst_beq;
                    3'b001:  inst_num = rv_pkg::inst_bne;
                    3'b100:  inst_num = rv_pkg::inst_blt;
                    3'b101:  inst_num = rv_pkg::inst_bge;
                    3'b110:  inst_num = rv_pkg::inst_bltu;
                    3'b111:  inst_num = rv_pkg::inst_bgeu;
                    default: inst_num = rv_pkg::inst_illegal;
                endcase
            end
            OP_IMM: begin
                inst_type = rv_pkg::type_i;
                case (word.r_fmt.funct3)
                    3'b000: inst_num = rv_pkg::inst_addi;
                    3'b011: inst_num = rv_pkg::inst_sltiu;
                    3'b100: inst_num = rv_pkg::inst_xori;
                    3'b111: inst_num = rv_pkg::inst_andi;
                    3'b001: begin
                        if (word.r_fmt.funct7 == 7'b0000000) inst_num = rv_pkg::inst_slli;
                    end
                    3'b101: begin
                        if (word.r_fmt.funct7 == 7'b0000000) inst_num = rv_pkg::inst_srli;
                        if (word.r_fmt.funct7 == 7'b0100000) inst_num = rv_pkg::inst_srai;
                    end
                    default: inst_num = rv_pkg::inst_illegal;
                endcase
            end
            OP_REG: begin
                inst_type = rv_pkg::type_r;
                if (word.r_fmt.funct7 == 7'b0000000) begin
                    case (word.r_fmt.funct3)
                        3'b000:  inst_num = rv_pkg::inst_add;
                        3'b001:  inst_num = rv_pkg::inst_sll;
                        3'b010:  inst_num = rv_pkg::inst_slt;
                        3'b011:  inst_num = rv_pkg::inst_sltu;
                        3'b100:  inst_num = rv_pkg::inst_xor;
                        3'b110:  inst_num = rv_pkg::inst_or;
                        3'b111:  inst_num = rv_pkg::inst_and;
                        default: inst_num = rv_pkg::inst_illegal;
                    endcase
                end else if (word.r_fmt.funct7 == 7'b0100000 && word.r_fmt.funct3 == 3'b000) begin
                    inst_num = rv_pkg::inst_sub;
                end
            end
            OP_SYSTEM: begin
                inst_type = rv_pkg::type_i;
                if (word.raw == EBREAK_WORD) inst_num = rv_pkg::inst_ebreak;
            end
            default: inst_num = rv_pkg::inst_illegal;
        endcase
        if (inst_num == rv_pkg::inst_illegal) inst_type = rv_pkg::type_none;
    end

    always_comb begin
        case (inst_type)
            rv_pkg::type_i: imm = {{(`XLEN-12){word.i_fmt.imm12[11]}}, word.i_fmt.imm12};
            rv_pkg::type_s: imm = {{(`XLEN-12){word.s_b_fmt.imm_hi[6]}},
                                   word.s_b_fmt.imm_hi, word.s_b_fmt.imm_lo};
            rv_pkg::type_b: imm = {{(`XLEN-12){word.s_b_fmt.imm_hi[6]}}, word.s_b_fmt.imm_lo[0],
                                   word.s_b_fmt.imm_hi[5:0], word.s_b_fmt.imm_lo[4:1], 1'b0};
            rv_pkg::type_u: imm = {word.u_fmt.imm20, 12'b0};
            rv_pkg::type_j: imm = {{(`XLEN-20){word.j_fmt.imm20[19]}}, word.j_fmt.imm20[7:0],
                                   word.j_fmt.imm20[8], word.j_fmt.imm20[18:9], 1'b0};
            default:        imm = '0; // R format and illegal words carry no immediate.
        endcase
    end

endmodule

//--- regfile.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module regfile (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [$clog2(`REG_NUM)-1:0]  rs1,
    input  logic [$clog2(`REG_NUM)-1:0]  rs2,
    output logic [`XLEN-1:0]             src1,
    output logic [`XLEN-1:0]             src2,
    input  logic                         w_en,
    input  logic [$clog2(`REG_NUM)-1:0]  rd,
    input  logic [`XLEN-1:0]             w_data
);

    logic [`XLEN-1:0] regs [`REG_NUM];

    // x0 is never written, so it keeps the value from reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en && rd != '0) begin
            regs[rd] <= w_data;
        end
    end

    // Reads are combinational so the operands are ready in the same cycle.
    assign src1 = (rs1 == '0) ? '0 : regs[rs1];
    assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- exu_alu.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module exu_alu (
    input  rv_pkg::inst_num_e inst_num,
    input  logic [`XLEN-1:0]  src1,
    input  logic [`XLEN-1:0]  src2,
    input  logic [`XLEN-1:0]  imm,
    input  logic [`XLEN-1:0]  pc,
    output logic [`XLEN-1:0]  alu_result
);

    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic             eq;
    logic             lt_s;
    logic             lt_u;

    // Immediate forms replace the second register operand.
    always_comb begin
        case (inst_num)
            rv_pkg::inst_addi,
            rv_pkg::inst_sltiu,
            rv_pkg::inst_xori,
            rv_pkg::inst_andi,
            rv_pkg::inst_slli,
            rv_pkg::inst_srli,
            rv_pkg::inst_srai: op_b = imm;
            default:           op_b = src2;
        endcase
    end

    assign shamt = op_b[4:0];
    assign eq    = (src1 == op_b);
    assign lt_s  = ($signed(src1) < $signed(op_b));
    assign lt_u  = (src1 < op_b);

    always_comb begin
        case (inst_num)
            rv_pkg::inst_lui:   alu_result = imm;
            rv_pkg::inst_auipc: alu_result = pc + imm;
            rv_pkg::inst_addi,
            rv_pkg::inst_add:   alu_result = src1 + op_b;
            rv_pkg::inst_sub:   alu_result = src1 - op_b;
            rv_pkg::inst_slli,
            rv_pkg::inst_sll:   alu_result = src1 << shamt;
            rv_pkg::inst_srli:  alu_result = src1 >> shamt;
            rv_pkg::inst_srai:  alu_result = $signed(src1) >>> shamt;
            rv_pkg::inst_slt:   alu_result = {{(`XLEN-1){1'b0}}, lt_s};
            rv_pkg::inst_sltiu,
            rv_pkg::inst_sltu:  alu_result = {{(`XLEN-1){1'b0}}, lt_u};
            rv_pkg::inst_xori,
            rv_pkg::inst_xor:   alu_result = src1 ^ op_b;
            rv_pkg::inst_or:    alu_result = src1 | op_b;
            rv_pkg::inst_andi,
            rv_pkg::inst_and:   alu_result = src1 & op_b;
            // Branch conditions land in bit 0 for exu_pc.
            rv_pkg::inst_beq:   alu_result = {{(`XLEN-1){1'b0}}, eq};
            rv_pkg::inst_bne:   alu_result = {{(`XLEN-1){1'b0}}, ~eq};
            rv_pkg::inst_blt:   alu_result = {{(`XLEN-1){1'b0}}, lt_s};
            rv_pkg::inst_bge:   alu_result = {{(`XLEN-1){1'b0}}, ~lt_s};
            rv_pkg::inst_bltu:  alu_result = {{(`XLEN-1){1'b0}}, lt_u};
            rv_pkg::inst_bgeu:  alu_result = {{(`XLEN-1){1'b0}}, ~lt_u};
            default:            alu_result = '0;
        endcase
    end

endmodule

//--- exu_pc.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module exu_pc (
    input  rv_pkg::inst_num_e  inst_num,
    input  rv_pkg::inst_type_e inst_type,
    input  logic [`XLEN-1:0]   imm,
    input  logic [`XLEN-1:0]   pc,
    input  logic [`XLEN-1:0]   src1,
    input  logic [`XLEN-1:0]   alu_result,
    output logic [`XLEN-1:0]   pc_in,
    output logic               pc_w_en
);

    logic             is_jalr;
    logic [`XLEN-1:0] adder_a;
    logic [`XLEN-1:0] adder_b;
    logic [`XLEN-1:0] adder_s;

    assign is_jalr = (inst_num == rv_pkg::inst_jalr);
    assign adder_a = is_jalr ? src1 : pc; // jalr is the only register-relative jump.

    always_comb begin
        case (inst_num)
            rv_pkg::inst_jal,
            rv_pkg::inst_jalr: adder_b = imm;
            rv_pkg::inst_beq,
            rv_pkg::inst_bne,
            rv_pkg::inst_blt,
            rv_pkg::inst_bge,
            rv_pkg::inst_bltu,
            rv_pkg::inst_bgeu: adder_b = alu_result[0] ? imm : `XLEN'd4;
            default:           adder_b = `XLEN'd4;
        endcase
    end

    assign adder_s = adder_a + adder_b;
    assign pc_in   = {adder_s[`XLEN-1:1], adder_s[0] & ~is_jalr};

    // Illegal words have no format, and ebreak must leave the PC where it halted.
    assign pc_w_en = (inst_type != rv_pkg::type_none) && (inst_num != rv_pkg::inst_ebreak);

endmodule

//--- core_top.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module core_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`XLEN-1:0]             inst,
    input  logic                         inst_valid,
    output logic                         inst_ready,
    output logic [`XLEN-1:0]             pc,
    output logic                         retire_valid,
    output logic [`XLEN-1:0]             retire_pc,
    output logic [$clog2(`REG_NUM)-1:0]  retire_rd,
    output logic [`XLEN-1:0]             retire_data,
    output logic                         halted
);

    rv_pkg::inst_num_e             inst_num;
    rv_pkg::inst_type_e            inst_type;
    logic [`XLEN-1:0]              imm;
    logic [$clog2(`REG_NUM)-1:0]   rs1;
    logic [$clog2(`REG_NUM)-1:0]   rs2;
    logic [$clog2(`REG_NUM)-1:0]   rd;
    logic [`XLEN-1:0]              src1;
    logic [`XLEN-1:0]              src2;
    logic [`XLEN-1:0]              alu_result;
    logic [`XLEN-1:0]              pc_in;
    logic                          pc_w_en;
    logic                          fire;
    logic                          writes_rd;
    logic                          is_branch;
    logic                          stop;
    logic [`XLEN-1:0]              pc_plus4;
    logic [`XLEN-1:0]              wb_data;

    assign inst_ready = ~halted;
    assign fire       = inst_valid & inst_ready;
    assign pc_plus4   = pc + `XLEN'd4;

    always_comb begin
        writes_rd = 1'b0;
        is_branch = 1'b0;
        case (inst_num)
            rv_pkg::inst_beq, rv_pkg::inst_bne, rv_pkg::inst_blt,
            rv_pkg::inst_bge, rv_pkg::inst_bltu, rv_pkg::inst_bgeu: is_branch = 1'b1;
            rv_pkg::inst_ebreak, rv_pkg::inst_illegal:              writes_rd = 1'b0;
            default:                                                writes_rd = 1'b1;
        endcase
    end

    assign stop    = (inst_num == rv_pkg::inst_ebreak) || (inst_num == rv_pkg::inst_illegal);
    assign wb_data = (inst_num == rv_pkg::inst_jal || inst_num == rv_pkg::inst_jalr) ?
                     pc_plus4 : alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= `RESET_PC;
            halted       <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= fire;
            if (fire && pc_w_en) pc <= pc_in;
            if (fire && stop) halted <= 1'b1; // Only reset clears it.
        end
    end

    // A branch reports the target it took, and a halting instruction reports zero.
    always_ff @(posedge clk) begin
        if (fire) begin
            retire_pc   <= pc;
            retire_rd   <= writes_rd ? rd : '0;
            retire_data <= writes_rd ? wb_data : (is_branch ? pc_in : '0);
        end
    end

    idu idu_i (
        .inst     (inst),
        .inst_num (inst_num),
        .inst_type(inst_type),
        .imm      (imm),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd)
    );

    regfile regfile_i (
        .clk   (clk),
        .rst   (rst),
        .rs1   (rs1),
        .rs2   (rs2),
        .src1  (src1),
        .src2  (src2),
        .w_en  (fire & writes_rd),
        .rd    (rd),
        .w_data(wb_data)
    );

    exu_alu exu_alu_i (
        .inst_num  (inst_num),
        .src1      (src1),
        .src2      (src2),
        .imm       (imm),
        .pc        (pc),
        .alu_result(alu_result)
    );

    exu_pc exu_pc_i (
        .inst_num  (inst_num),
        .inst_type (inst_type),
        .imm       (imm),
        .pc        (pc),
        .src1      (src1),
        .alu_result(alu_result),
        .pc_in     (pc_in),
        .pc_w_en   (pc_w_en)
    );

endmodule

//--- tb_core.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module tb_core;

    localparam int TOTAL_INSTS = 63; // Instructions executed over all tests.
    localparam int LIMIT_CYCLES = TOTAL_INSTS * 20 + 40;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] pc;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        halted;

    logic [31:0] prog [logic [31:0]];
    logic [31:0] mregs [32];
    logic [31:0] model_pc;
    logic        model_halted;
    logic [31:0] base;
    logic        last_fire;

    core_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .inst_ready  (inst_ready),
        .pc          (pc),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_rd   (retire_rd),
        .retire_data (retire_data),
        .halted      (halted)
    );

    always #5 clk = ~clk;

    task automatic die(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else
            die($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        rv_pkg::inst_word_u w;
        w.r_fmt = '{f7, rs2, rs1, f3, rd, 7'b0110011};
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        rv_pkg::inst_word_u w;
        w.i_fmt = '{imm, rs1, f3, rd, op};
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        rv_pkg::inst_word_u w;
        w.s_b_fmt = '{{imm[12], imm[10:5]}, rs2, rs1, f3, {imm[4:1], imm[11]}, 7'b1100011};
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        rv_pkg::inst_word_u w;
        w.s_b_fmt = '{imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        rv_pkg::inst_word_u w;
        w.u_fmt = '{imm, rd, op};
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        rv_pkg::inst_word_u w;
        w.j_fmt = '{{imm[20], imm[10:1], imm[11], imm[19:12]}, rd, 7'b1101111};
        return w.raw;
    endfunction

    // ISA reference model. Returns the expected retire fields and advances its own state.
    task automatic model_exec(input logic [31:0] w, output logic [4:0] exp_rd,
                              output logic [31:0] exp_data);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] next;
        logic [31:0] data;
        logic        wr;
        logic        legal;
        logic        branch;
        logic        take;
        a      = mregs[w[19:15]];
        b      = mregs[w[24:20]];
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_b  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        next   = model_pc + 4;
        data   = 0;
        wr     = 1'b1;
        legal  = 1'b1;
        branch = 1'b0;
        take   = 1'b0;
        case (w[6:0])
            7'b0110111: data = {w[31:12], 12'b0};
            7'b0010111: data = model_pc + {w[31:12], 12'b0};
            7'b1101111: begin
                data = model_pc + 4;
                next = model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100111: begin
                legal = (w[14:12] == 3'b000);
                data  = model_pc + 4;
                next  = (a + imm_i) & ~32'h1;
            end
            7'b1100011: begin
                wr     = 1'b0;
                branch = 1'b1;
                case (w[14:12])
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: legal = 1'b0;
                endcase
                if (take) next = model_pc + imm_b;
            end
            7'b0010011: begin
                case (w[14:12])
                    3'b000:  data = a + imm_i;
                    3'b011:  data = {31'b0, a < imm_i};
                    3'b100:  data = a ^ imm_i;
                    3'b111:  data = a & imm_i;
                    3'b001: begin
                        legal = (w[31:25] == 7'b0000000);
                        data  = a << imm_i[4:0];
                    end
                    3'b101: begin
                        legal = (w[31:25] == 7'b0000000) || (w[31:25] == 7'b0100000);
                        if (w[30]) begin
                            data = $signed(a) >>> imm_i[4:0];
                        end else begin
                            data = a >> imm_i[4:0];
                        end
                    end
                    default: legal = 1'b0;
                endcase
            end
            7'b0110011: begin
                case ({w[31:25], w[14:12]})
                    10'b0000000_000: data = a + b;
                    10'b0100000_000: data = a - b;
                    10'b0000000_001: data = a << b[4:0];
                    10'b0000000_010: data = {31'b0, $signed(a) < $signed(b)};
                    10'b0000000_011: data = {31'b0, a < b};
                    10'b0000000_100: data = a ^ b;
                    10'b0000000_110: data = a | b;
                    10'b0000000_111: data = a & b;
                    default:         legal = 1'b0;
                endcase
            end
            default: legal = 1'b0; // ebreak is caught below.
        endcase
        if (!legal || w == 32'h0010_0073) begin
            wr           = 1'b0;
            branch       = 1'b0;
            next         = model_pc;
            model_halted = 1'b1;
        end
        exp_rd   = wr ? w[11:7] : 5'd0;
        exp_data = wr ? data : (branch ? next : 32'd0);
        if (wr && w[11:7] != 0) mregs[w[11:7]] = data;
        model_pc = next;
    endtask

    task automatic exec_one(input bit gaps);
        int          idle;
        logic [31:0] word;
        logic [31:0] exp_pc;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        idle = gaps ? $urandom_range(3, 0) : 0;
        @(posedge clk);
        repeat (idle) @(posedge clk);
        #1;
        check_eq(pc, model_pc, "pc");
        check_eq({31'b0, inst_ready}, 32'd1, "inst_ready before issue");
        if (!prog.exists(pc)) die("Program store holds no instruction at the current pc.");
        word   = prog[pc];
        exp_pc = model_pc;
        model_exec(word, exp_rd, exp_data);
        @(posedge clk);
        inst       <= word;
        inst_valid <= 1'b1;
        @(posedge clk);
        inst_valid <= 1'b0; // Accepted on this edge since inst_ready was high.
        inst       <= $urandom;
        #1;
        check_eq({31'b0, retire_valid}, 32'd1, "retire_valid");
        check_eq(retire_pc, exp_pc, "retire_pc");
        check_eq({27'b0, retire_rd}, {27'b0, exp_rd}, "retire_rd");
        check_eq(retire_data, exp_data, "retire_data");
        check_eq({31'b0, halted}, {31'b0, model_halted}, "halted");
    endtask

    task automatic place(input int idx, input logic [31:0] word);
        prog[base + 4 * idx] = word;
    endtask

    task automatic start_program();
        prog.delete();
        base = model_pc;
    endtask

    task automatic do_reset();
        @(posedge clk);
        rst        <= 1'b1;
        inst_valid <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = 0;
        end
        model_pc     = `RESET_PC;
        model_halted = 1'b0;
        @(posedge clk);
        #1;
        check_eq(pc, `RESET_PC, "pc after reset");
        check_eq({31'b0, retire_valid}, 32'd0, "retire_valid after reset");
        check_eq({31'b0, halted}, 32'd0, "halted after reset");
        check_eq({31'b0, inst_ready}, 32'd1, "inst_ready after reset");
    endtask

    task automatic test_arith(input bit gaps);
        start_program();
        place(0, enc_i(12'hFFB, 0, 3'b000, 1, 7'b0010011));
        place(1, enc_i(12'd7, 0, 3'b000, 2, 7'b0010011));
        place(2, enc_r(7'h00, 2, 1, 3'b000, 3));
        place(3, enc_r(7'h20, 2, 1, 3'b000, 4));
        place(4, enc_r(7'h00, 2, 2, 3'b001, 5));
        place(5, enc_r(7'h00, 2, 1, 3'b010, 6));
        place(6, enc_r(7'h00, 2, 1, 3'b011, 7));
        place(7, enc_r(7'h00, 2, 1, 3'b100, 8));
        place(8, enc_r(7'h00, 2, 1, 3'b110, 9));
        place(9, enc_r(7'h00, 2, 1, 3'b111, 10));
        place(10, enc_i(12'hFFF, 2, 3'b011, 11, 7'b0010011));
        place(11, enc_i(12'h555, 1, 3'b100, 12, 7'b0010011));
        place(12, enc_i(12'h0F0, 1, 3'b111, 13, 7'b0010011));
        place(13, enc_i(12'h003, 1, 3'b001, 14, 7'b0010011));
        place(14, enc_i(12'h004, 1, 3'b101, 15, 7'b0010011));
        place(15, enc_i(12'h404, 1, 3'b101, 16, 7'b0010011));
        place(16, enc_i(12'd5, 2, 3'b000, 0, 7'b0010011));
        place(17, enc_r(7'h00, 2, 0, 3'b000, 17)); // Reads x0 back after the write above.
        repeat (18) exec_one(gaps);
    endtask

    task automatic test_branches();
        logic [31:0] skip;
        skip = enc_i(12'd1, 0, 3'b000, 20, 7'b0010011);
        start_program();
        place(0, enc_b(13'd8, 2, 2, 3'b000));
        place(1, skip);
        place(2, enc_b(13'd8, 2, 2, 3'b001));
        place(3, enc_b(13'd8, 2, 1, 3'b100));
        place(4, skip);
        place(5, enc_b(13'd8, 2, 1, 3'b110));
        place(6, enc_b(13'd8, 2, 1, 3'b101));
        place(7, enc_b(13'd8, 2, 1, 3'b111));
        place(8, skip);
        place(9, enc_b(13'd8, 2, 1, 3'b001));
        place(10, skip);
        place(11, enc_i(12'd3, 0, 3'b000, 21, 7'b0010011));
        // x22 is the most negative value and x23 the most positive one.
        place(12, enc_u(20'h80000, 22, 7'b0110111));
        place(13, enc_i(12'hFFF, 22, 3'b000, 23, 7'b0010011));
        place(14, enc_b(13'd8, 22, 23, 3'b000));
        place(15, enc_b(13'd8, 22, 23, 3'b100));
        place(16, enc_b(13'd8, 22, 23, 3'b101));
        place(17, skip);
        place(18, enc_b(13'd8, 22, 23, 3'b110));
        place(19, skip);
        place(20, enc_b(13'd8, 22, 23, 3'b111));
        place(21, enc_i(12'd3, 0, 3'b000, 21, 7'b0010011));
        repeat (16) exec_one(1'b0);
    endtask

    task automatic test_jumps();
        logic [31:0] skip;
        skip = enc_i(12'd1, 0, 3'b000, 20, 7'b0010011);
        start_program();
        place(0, enc_j(21'd8, 1));
        place(1, skip);
        place(2, enc_u(20'd0, 5, 7'b0010111));
        place(3, enc_i(12'd21, 5, 3'b000, 6, 7'b1100111)); // Odd sum, lands on index 7.
        place(4, skip);
        place(5, skip);
        place(6, skip);
        place(7, enc_i(12'd9, 0, 3'b000, 7, 7'b0010011));
        repeat (4) exec_one(1'b0);
    endtask

    task automatic test_upper();
        start_program();
        place(0, enc_u(20'hABCDE, 8, 7'b0110111));
        place(1, enc_u(20'h12345, 9, 7'b0010111));
        place(2, enc_u(20'h80000, 10, 7'b0110111));
        place(3, enc_u(20'hFFFFF, 11, 7'b0010111));
        repeat (4) exec_one(1'b0);
    endtask

    task automatic check_stays_halted();
        logic [31:0] held_pc;
        held_pc = model_pc;
        check_eq({31'b0, halted}, 32'd1, "halted");
        check_eq({31'b0, inst_ready}, 32'd0, "inst_ready while halted");
        check_eq(pc, held_pc, "pc at halt");
        @(posedge clk);
        inst       <= enc_i(12'd1, 0, 3'b000, 1, 7'b0010011);
        inst_valid <= 1'b1;
        repeat (10) @(posedge clk);
        inst_valid <= 1'b0;
        #1;
        check_eq(pc, held_pc, "pc while halted");
        check_eq({31'b0, halted}, 32'd1, "halted later");
    endtask

    task automatic test_halt_ebreak();
        start_program();
        place(0, enc_i(12'd1, 0, 3'b000, 3, 7'b0010011));
        place(1, 32'h0010_0073);
        repeat (2) exec_one(1'b0);
        check_stays_halted();
    endtask

    task automatic test_halt_store();
        do_reset();
        start_program();
        place(0, enc_s(12'd0, 1, 2));
        exec_one(1'b0);
        check_stays_halted();
    endtask

    // Every acceptance must give exactly one retire pulse on the next cycle.
    always @(posedge clk) begin
        if (rst) begin
            last_fire <= 1'b0;
        end else begin
            assert (retire_valid === last_fire) else
                die($sformatf("CHECK FAILED at %0t: retire_valid is %b, expected %b",
                              $time, retire_valid, last_fire));
            last_fire <= inst_valid & inst_ready;
        end
    end

    initial begin
        #(LIMIT_CYCLES * 10);
        die("The run timed out before all tests finished.");
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        inst       = 32'h0;
        inst_valid = 1'b0;
        void'($urandom(32'h68856a57));
        do_reset();
        test_arith(1'b0);
        test_branches();
        test_jumps();
        test_upper();
        test_arith(1'b1);
        test_halt_ebreak();
        test_halt_store();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
rv_pkg.sv
idu.sv
regfile.sv
exu_alu.sv
exu_pc.sv
core_top.sv
tb_core.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_core -o tb_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator compilation failed"
    exit 1
fi

out=$(./obj_dir/tb_core_sim 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
